/* common/core_pkg.sv */
// core widths, depths and function codes

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH       = 32;
    localparam int REG_IDX_WIDTH    = 5;
    localparam int NUM_LANES        = 3;   // exec lanes == completion ports
    localparam int RETIRE_WIDTH     = 3;   // max retires per cycle
    localparam int ROB_DEPTH        = 8;
    localparam int ROB_TAG_WIDTH    = $clog2(ROB_DEPTH);
    localparam int LANE_QUEUE_DEPTH = 2;   // also the reset credit per lane
    localparam int MUL_LATENCY      = 4;   // cycles a multiply holds a lane

    //////////////////////////////////////////////////////////////////////
    // typedefs
    //////////////////////////////////////////////////////////////////////

    typedef logic [DATA_WIDTH-1:0]    data_t;      // operand / result word
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;   // arch dest index
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;   // rob slot number
    typedef logic [2:0]               alu_func_t;
    typedef logic [1:0]               retire_count_t;

    // occupancy 0..ROB_DEPTH needs one bit more than a tag
    typedef logic [ROB_TAG_WIDTH:0]   rob_count_t;

    // credits and lane queue fill, 0..LANE_QUEUE_DEPTH
    typedef logic [$clog2(LANE_QUEUE_DEPTH+1)-1:0] credit_t;

    // lane select and round-robin pointer
    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

    //////////////////////////////////////////////////////////////////////
    // alu function codes
    //////////////////////////////////////////////////////////////////////

    localparam alu_func_t FUNC_ADD = 3'd0;
    localparam alu_func_t FUNC_SUB = 3'd1;
    localparam alu_func_t FUNC_AND = 3'd2;
    localparam alu_func_t FUNC_OR  = 3'd3;
    localparam alu_func_t FUNC_XOR = 3'd4;
    localparam alu_func_t FUNC_SLT = 3'd5;  // signed compare, 0 or 1
    localparam alu_func_t FUNC_MUL = 3'd6;  // low word of the product

endpackage

/* common/lane_if.sv */
// issue and completion bus of one lane

`timescale 1ns/1ps

interface lane_if;
    import core_pkg::*;

    // dispatcher to lane
    logic      issue_valid;  // one-cycle pulse per issued op
    rob_tag_t  issue_tag;
    alu_func_t issue_func;
    data_t     issue_a;
    data_t     issue_b;

    // lane back to dispatcher
    logic      credit_return;  // pulses when an op leaves the lane queue

    // lane to reorder buffer, one completion port
    logic      done_valid;
    rob_tag_t  done_tag;
    data_t     done_value;

    modport issuer (
        output issue_valid, issue_tag, issue_func, issue_a, issue_b,
        input  credit_return
    );

    modport lane (
        input  issue_valid, issue_tag, issue_func, issue_a, issue_b,
        output credit_return,
        output done_valid, done_tag, done_value
    );

    modport completer (
        input  done_valid, done_tag, done_value
    );

endinterface

/* common/alloc_if.sv */
// rob entry allocation

`timescale 1ns/1ps

interface alloc_if;
    import core_pkg::*;

    logic     alloc_valid;  // one entry taken per edge while high
    reg_idx_t alloc_dest;   // dest recorded in the new entry
    rob_tag_t alloc_tag;    // current tail slot
    logic     rob_full;

    modport requester (
        output alloc_valid, alloc_dest,
        input  alloc_tag, rob_full
    );

    modport allocator (
        input  alloc_valid, alloc_dest,
        output alloc_tag, rob_full
    );

endinterface

/* rtl/dispatch_unit.sv */
// instruction dispatch with lane credits

`timescale 1ns/1ps

module dispatch_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  core_pkg::alu_func_t  in_func,
    input  core_pkg::data_t      in_src_a,
    input  core_pkg::data_t      in_src_b,
    input  core_pkg::reg_idx_t   in_dest,
    output logic                 in_ready,
    alloc_if.requester           alloc,
    lane_if.issuer               lanes [core_pkg::NUM_LANES]
);
    import core_pkg::*;

    credit_t              credit_q [NUM_LANES];  // free queue slots per lane
    logic [NUM_LANES-1:0] credit_ret;
    logic [NUM_LANES-1:0] issue_sel;             // lane picked this cycle
    logic [NUM_LANES-1:0] issue_valid_q;
    lane_idx_t            rr_ptr;
    lane_idx_t            sel_lane;
    logic                 sel_found;
    logic                 accept;

    // issue payload, shared by all lanes since only the valid differs
    rob_tag_t  issue_tag_q;
    alu_func_t issue_func_q;
    data_t     issue_a_q;
    data_t     issue_b_q;

    //////////////////////////////////////////////////////////////////////
    // lane pick
    //////////////////////////////////////////////////////////////////////

    // walk backwards so the lane nearest the pointer wins
    always_comb begin
        int idx;
        sel_found = 1'b0;
        sel_lane  = rr_ptr;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM_LANES;
            if (credit_q[idx] != '0) begin
                sel_found = 1'b1;
                sel_lane  = lane_idx_t'(idx);
            end
        end
    end

    assign in_ready = sel_found && !alloc.rob_full;  // independent of in_valid
    assign accept   = in_valid && in_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            issue_sel[i] = accept && (sel_lane == lane_idx_t'(i));
        end
    end

    // tag is allocated on the accepting edge
    assign alloc.alloc_valid = accept;
    assign alloc.alloc_dest  = in_dest;

    //////////////////////////////////////////////////////////////////////
    // credits and pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_q[i] <= credit_t'(LANE_QUEUE_DEPTH);
            end
            issue_valid_q <= '0;
            rr_ptr        <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_q[i] <= credit_q[i] + credit_t'(credit_ret[i])
                               - credit_t'(issue_sel[i]);
            end
            issue_valid_q <= issue_sel;  // single cycle pulse
            if (accept) begin
                // step past the lane just used
                rr_ptr <= (sel_lane == lane_idx_t'(NUM_LANES - 1)) ? '0 : sel_lane + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            issue_tag_q  <= alloc.alloc_tag;
            issue_func_q <= in_func;
            issue_a_q    <= in_src_a;
            issue_b_q    <= in_src_b;
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lanes[g].issue_valid = issue_valid_q[g];
        assign lanes[g].issue_tag   = issue_tag_q;
        assign lanes[g].issue_func  = issue_func_q;
        assign lanes[g].issue_a     = issue_a_q;
        assign lanes[g].issue_b     = issue_b_q;
        assign credit_ret[g]        = lanes[g].credit_return;
    end

endmodule

/* exec_lane/exec_lane.sv */
// execution lane with input queue

`timescale 1ns/1ps

module exec_lane (
    input  logic  clock,
    input  logic  reset,
    lane_if.lane  issue,
    lane_if.lane  done
);
    import core_pkg::*;

    typedef enum logic {
        LANE_IDLE,
        LANE_BUSY
    } lane_state_t;

    typedef logic [$clog2(LANE_QUEUE_DEPTH)-1:0] q_ptr_t;    // queue slot
    typedef logic [$clog2(MUL_LATENCY)-1:0]      mul_cnt_t;  // cycles left of an op

    // input queue, sized to the credits handed out
    alu_func_t q_func [LANE_QUEUE_DEPTH];
    rob_tag_t  q_tag  [LANE_QUEUE_DEPTH];
    data_t     q_a    [LANE_QUEUE_DEPTH];
    data_t     q_b    [LANE_QUEUE_DEPTH];
    q_ptr_t    q_wr_ptr;
    q_ptr_t    q_rd_ptr;
    credit_t   q_count;

    // op in execution
    lane_state_t state_q;
    mul_cnt_t    cnt_q;   // cycles left before done
    alu_func_t   ex_func;
    rob_tag_t    ex_tag;
    data_t       ex_a;
    data_t       ex_b;
    data_t       result;

    logic lane_free;
    logic pop;
    logic finish;

    // a lane in its last cycle can take the next op at the same edge
    assign finish    = (state_q == LANE_BUSY) && (cnt_q == '0);
    assign lane_free = (state_q == LANE_IDLE) || finish;
    assign pop       = lane_free && (q_count != '0);

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_func)
            FUNC_ADD: result = ex_a + ex_b;
            FUNC_SUB: result = ex_a - ex_b;
            FUNC_AND: result = ex_a & ex_b;
            FUNC_OR:  result = ex_a | ex_b;
            FUNC_XOR: result = ex_a ^ ex_b;
            FUNC_SLT: result = data_t'($signed(ex_a) < $signed(ex_b));
            FUNC_MUL: result = ex_a * ex_b;   // truncates to low word
            default:  result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q             <= LANE_IDLE;
            cnt_q               <= '0;
            q_wr_ptr            <= '0;
            q_rd_ptr            <= '0;
            q_count             <= '0;
            issue.credit_return <= 1'b0;
            done.done_valid     <= 1'b0;
        end else begin
            issue.credit_return <= pop;     // slot freed, credit back
            done.done_valid     <= finish;  // one-cycle pulse
            if (issue.issue_valid) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_count <= q_count + credit_t'(issue.issue_valid) - credit_t'(pop);

            if (pop) begin
                state_q <= LANE_BUSY;
                // multiply holds the lane MUL_LATENCY cycles
                cnt_q   <= (q_func[q_rd_ptr] == FUNC_MUL) ?
                           mul_cnt_t'(MUL_LATENCY - 1) : '0;
            end else if (finish) begin
                state_q <= LANE_IDLE;
            end else if (state_q == LANE_BUSY) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (issue.issue_valid) begin
            q_func[q_wr_ptr] <= issue.issue_func;
            q_tag[q_wr_ptr]  <= issue.issue_tag;
            q_a[q_wr_ptr]    <= issue.issue_a;
            q_b[q_wr_ptr]    <= issue.issue_b;
        end
        if (pop) begin
            ex_func <= q_func[q_rd_ptr];
            ex_tag  <= q_tag[q_rd_ptr];
            ex_a    <= q_a[q_rd_ptr];
            ex_b    <= q_b[q_rd_ptr];
        end
        if (finish) begin
            done.done_tag   <= ex_tag;
            done.done_value <= result;
        end
    end

endmodule

/* rob/reorder_buffer.sv */
// reorder buffer with in-order retire

`timescale 1ns/1ps

module reorder_buffer (
    input  logic                          clock,
    input  logic                          reset,
    alloc_if.allocator                    alloc,
    lane_if.completer                     lanes [core_pkg::NUM_LANES],
    output logic [core_pkg::RETIRE_WIDTH-1:0] commit_valid,
    output logic [core_pkg::RETIRE_WIDTH-1:0] commit_wr_en,
    output core_pkg::reg_idx_t            commit_wr_idx  [core_pkg::RETIRE_WIDTH],
    output core_pkg::data_t               commit_wr_data [core_pkg::RETIRE_WIDTH],
    output core_pkg::retire_count_t       completed_insts
);
    import core_pkg::*;

    // entry state
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;   // result written back
    reg_idx_t             ent_dest  [ROB_DEPTH];
    data_t                ent_value [ROB_DEPTH];

    rob_tag_t   head_q;    // oldest entry
    rob_tag_t   tail_q;    // next free slot
    rob_count_t count_q;

    // completion ports, one per lane
    logic [NUM_LANES-1:0] cmp_valid;
    rob_tag_t             cmp_tag   [NUM_LANES];
    data_t                cmp_value [NUM_LANES];

    rob_tag_t ret_slot [RETIRE_WIDTH];  // slots looked at for retire

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_cmp
        assign cmp_valid[g] = lanes[g].done_valid;
        assign cmp_tag[g]   = lanes[g].done_tag;
        assign cmp_value[g] = lanes[g].done_value;
    end

    assign alloc.alloc_tag = tail_q;
    assign alloc.rob_full  = (count_q == rob_count_t'(ROB_DEPTH));

    //////////////////////////////////////////////////////////////////////
    // retire select
    //////////////////////////////////////////////////////////////////////

    // consecutive done entries from the head, stops at the first gap
    always_comb begin
        logic run;
        run             = 1'b1;
        completed_insts = '0;
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            ret_slot[k]       = head_q + rob_tag_t'(k);  // wraps with the pointer width
            run               = run && ent_valid[ret_slot[k]] && ent_done[ret_slot[k]];
            commit_valid[k]   = run;
            // register zero is never written
            commit_wr_en[k]   = run && (ent_dest[ret_slot[k]] != '0);
            commit_wr_idx[k]  = ent_dest[ret_slot[k]];
            commit_wr_data[k] = ent_value[ret_slot[k]];
            completed_insts   = completed_insts + retire_count_t'(run);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
        end else begin
            for (int k = 0; k < RETIRE_WIDTH; k++) begin
                if (commit_valid[k]) begin
                    ent_valid[ret_slot[k]] <= 1'b0;
                end
            end
            // tail is never a retiring slot, dispatcher stalls on full
            if (alloc.alloc_valid) begin
                ent_valid[tail_q] <= 1'b1;
                ent_done[tail_q]  <= 1'b0;
                tail_q            <= tail_q + 1'b1;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (cmp_valid[l]) begin
                    ent_done[cmp_tag[l]] <= 1'b1;  // eligible next cycle
                end
            end
            head_q  <= head_q + rob_tag_t'(completed_insts);
            count_q <= count_q + rob_count_t'(alloc.alloc_valid)
                       - rob_count_t'(completed_insts);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc.alloc_valid) begin
            ent_dest[tail_q] <= alloc.alloc_dest;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (cmp_valid[l]) begin
                ent_value[cmp_tag[l]] <= cmp_value[l];  // tags in flight are unique
            end
        end
    end

endmodule

/* rtl/ooo_core.sv */
// out-of-order core back end

`timescale 1ns/1ps

module ooo_core (
    input  logic                              clock,
    input  logic                              reset,

    // instruction input, operands already read
    input  logic                              in_valid,
    input  core_pkg::alu_func_t               in_func,
    input  core_pkg::data_t                   in_src_a,
    input  core_pkg::data_t                   in_src_b,
    input  core_pkg::reg_idx_t                in_dest,
    output logic                              in_ready,

    // commit side, no back-pressure
    output logic [core_pkg::RETIRE_WIDTH-1:0] commit_valid,
    output logic [core_pkg::RETIRE_WIDTH-1:0] commit_wr_en,
    output core_pkg::reg_idx_t                commit_wr_idx  [core_pkg::RETIRE_WIDTH],
    output core_pkg::data_t                   commit_wr_data [core_pkg::RETIRE_WIDTH],
    output core_pkg::retire_count_t           completed_insts
);
    import core_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // buses
    //////////////////////////////////////////////////////////////////////

    alloc_if alloc_bus ();
    lane_if  lane_bus [NUM_LANES] ();  // issue + completion per lane

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    dispatch_unit u_dispatch (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_func  (in_func),
        .in_src_a (in_src_a),
        .in_src_b (in_src_b),
        .in_dest  (in_dest),
        .in_ready (in_ready),
        .alloc    (alloc_bus),
        .lanes    (lane_bus)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        // issue and done sides of the same bus
        exec_lane u_lane (
            .clock (clock),
            .reset (reset),
            .issue (lane_bus[g]),
            .done  (lane_bus[g])
        );
    end

    reorder_buffer u_rob (
        .clock           (clock),
        .reset           (reset),
        .alloc           (alloc_bus),
        .lanes           (lane_bus),
        .commit_valid    (commit_valid),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .completed_insts (completed_insts)
    );

endmodule

/* testbench/tb_ooo_core.sv */
// ooo core back end testbench

`timescale 1ns/1ps

module tb_ooo_core;
    import core_pkg::*;

    localparam int N_INSTR        = 300;
    localparam int MUL_BURST      = 24;  // leading all-multiply burst
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = N_INSTR * (MUL_LATENCY + 4) + 200;

    logic                    clock;
    logic                    reset;
    logic                    in_valid;
    alu_func_t               in_func;
    data_t                   in_src_a;
    data_t                   in_src_b;
    reg_idx_t                in_dest;
    logic                    in_ready;
    logic [RETIRE_WIDTH-1:0] commit_valid;
    logic [RETIRE_WIDTH-1:0] commit_wr_en;
    reg_idx_t                commit_wr_idx  [RETIRE_WIDTH];
    data_t                   commit_wr_data [RETIRE_WIDTH];
    retire_count_t           completed_insts;

    // reference model, oldest uncommitted first
    data_t    exp_q  [$];
    reg_idx_t dest_q [$];
    data_t    exp_data [RETIRE_WIDTH];  // model head seen by each commit lane
    reg_idx_t exp_dest [RETIRE_WIDTH];
    int       model_size;
    int       accepted;
    int       committed;

    // handshake and retire count seen at the last rising edge
    logic          acc_q;
    retire_count_t ret_q;

    logic   rst_win;     // reset plus one cycle
    logic   stall_seen;
    integer seed;
    int     burst_left;
    int     cycles;
    int     reset_errors;
    int     data_errors;
    int     dest_errors;
    int     count_errors;
    int     flow_errors;

    ooo_core dut_i (
        .clock           (clock),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_func         (in_func),
        .in_src_a        (in_src_a),
        .in_src_b        (in_src_b),
        .in_dest         (in_dest),
        .in_ready        (in_ready),
        .commit_valid    (commit_valid),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .completed_insts (completed_insts)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        if (reset) begin
            acc_q <= 1'b0;
            ret_q <= '0;
        end else begin
            acc_q <= in_valid && in_ready;  // accepted at this edge
            ret_q <= completed_insts;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic data_t ref_result(alu_func_t func, data_t a, data_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (func)
            FUNC_ADD: return a + b;
            FUNC_SUB: return a - b;
            FUNC_AND: return a & b;
            FUNC_OR:  return a | b;
            FUNC_XOR: return a ^ b;
            FUNC_SLT: return (int'(a) < int'(b)) ? 32'd1 : 32'd0;  // signed view
            FUNC_MUL: return prod[31:0];
            default:  return '0;
        endcase
    endfunction

    // book the last edge, called on the falling edge
    task automatic update_model();
        if (acc_q) begin
            exp_q.push_back(ref_result(in_func, in_src_a, in_src_b));
            dest_q.push_back(in_dest);
            accepted++;
        end
        for (int i = 0; i < int'(ret_q); i++) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(dest_q.pop_front());
            end
            committed++;
        end
        model_size = exp_q.size();
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            exp_data[k] = (k < model_size) ? exp_q[k] : '0;
            exp_dest[k] = (k < model_size) ? dest_q[k] : '0;
        end
        if (!in_ready && accepted <= MUL_BURST) begin
            stall_seen = 1'b1;
        end
    endtask

    task automatic drive_next();
        logic [31:0] r;
        if (in_valid && !acc_q) begin
            return;  // still offered, hold it
        end
        if (accepted >= N_INSTR) begin
            in_valid = 1'b0;
            return;
        end
        if (accepted >= MUL_BURST && burst_left == 0) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                in_valid = 1'b0;  // gap between bursts
                return;
            end
            burst_left = 1 + int'(r[5:2]);
        end
        r = $random(seed);
        in_valid = 1'b1;
        if (accepted < MUL_BURST || (r % 3) == 0) begin
            in_func = FUNC_MUL;
        end else begin
            in_func = r[10:8] % 3'd6;  // add .. slt
        end
        in_dest  = (r[14:12] == 3'd0) ? '0 : r[20:16];  // some writes to r0
        in_src_a = $random(seed);
        in_src_b = $random(seed);
        if (burst_left > 0) begin
            burst_left--;
        end
    endtask

    task automatic report_error_counts();
        $display("errors: reset %0d, data %0d, dest %0d, count %0d, flow %0d",
                 reset_errors, data_errors, dest_errors, count_errors, flow_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clock) rst_win |-> (commit_valid == '0 && in_ready))
    else begin
        reset_errors++;
        $display("CHECK FAILED commit_valid: expected %h, got %h; in_ready: expected 1, got %h",
                 {RETIRE_WIDTH{1'b0}}, $sampled(commit_valid), $sampled(in_ready));
    end

    assert property (@(posedge clock) disable iff (reset)
        int'(completed_insts) == $countones(commit_valid))
    else begin
        count_errors++;
        $display("CHECK FAILED completed_insts: expected %h, got %h",
                 $countones($sampled(commit_valid)), $sampled(completed_insts));
    end

    // set bits form a run from lane 0
    assert property (@(posedge clock) disable iff (reset)
        ((commit_valid + RETIRE_WIDTH'(1)) & commit_valid) == '0)
    else begin
        count_errors++;
        $display("commit_valid %h is not a run of lanes starting at lane 0",
                 $sampled(commit_valid));
    end

    assert property (@(posedge clock) disable iff (reset)
        (accepted - committed) <= ROB_DEPTH)
    else begin
        flow_errors++;
        $display("more than %0d instructions in flight", ROB_DEPTH);
    end

    for (genvar k = 0; k < RETIRE_WIDTH; k++) begin : g_commit_chk
        assert property (@(posedge clock) disable iff (reset)
            commit_valid[k] |-> (model_size > k))
        else begin
            flow_errors++;
            $display("commit lane %0d retired an instruction that was never accepted", k);
        end

        assert property (@(posedge clock) disable iff (reset)
            (commit_valid[k] && model_size > k) |-> (commit_wr_data[k] == exp_data[k]))
        else begin
            data_errors++;
            $display("CHECK FAILED commit_wr_data[%0d]: expected %h, got %h",
                     k, exp_data[k], $sampled(commit_wr_data[k]));
        end

        assert property (@(posedge clock) disable iff (reset)
            (commit_valid[k] && model_size > k) |-> (commit_wr_idx[k] == exp_dest[k]))
        else begin
            dest_errors++;
            $display("CHECK FAILED commit_wr_idx[%0d]: expected %h, got %h",
                     k, exp_dest[k], $sampled(commit_wr_idx[k]));
        end

        // write enable follows the recorded dest, r0 is never written
        assert property (@(posedge clock) disable iff (reset)
            commit_wr_en[k] == (commit_valid[k] && (exp_dest[k] != '0)))
        else begin
            dest_errors++;
            $display("CHECK FAILED commit_wr_en[%0d]: expected %h, got %h", k,
                     $sampled(commit_valid[k]) && (exp_dest[k] != '0),
                     $sampled(commit_wr_en[k]));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_func      = FUNC_ADD;
        in_src_a     = '0;
        in_src_b     = '0;
        in_dest      = '0;
        rst_win      = 1'b0;
        stall_seen   = 1'b0;
        seed         = 32'hc371;
        burst_left   = 0;
        accepted     = 0;
        committed    = 0;
        model_size   = 0;
        reset_errors = 0;
        data_errors  = 0;
        dest_errors  = 0;
        count_errors = 0;
        flow_errors  = 0;
        for (int k = 0; k < RETIRE_WIDTH; k++) begin
            exp_data[k] = '0;
            exp_dest[k] = '0;
        end

        @(negedge clock);
        rst_win = 1'b1;  // first reset edge is behind us
        repeat (RESET_CYCLES - 1) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        rst_win = 1'b0;

        while (committed < N_INSTR) begin
            update_model();
            drive_next();
            @(negedge clock);
        end

        // idle tail, stray commits would show up here
        repeat (4) begin
            update_model();
            @(negedge clock);
        end

        if (accepted != N_INSTR || committed != N_INSTR || model_size != 0) begin
            flow_errors++;
            $display("instructions lost or duplicated: accepted %0d, committed %0d",
                     accepted, committed);
        end
        if (!stall_seen) begin
            flow_errors++;
            $display("in_ready never went low during the multiply burst");
        end

        report_error_counts();
        if (reset_errors + data_errors + dest_errors + count_errors + flow_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, commits stalled at %0d of %0d",
                 cycles, committed, N_INSTR);
        report_error_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* sources.f */
common/core_pkg.sv
common/lane_if.sv
common/alloc_if.sv
rtl/dispatch_unit.sv
exec_lane/exec_lane.sv
rob/reorder_buffer.sv
rtl/ooo_core.sv
testbench/tb_ooo_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ooo_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ooo_core \
    -f sources.f

output="$(./obj_dir/Vtb_ooo_core)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
